// ==== Bender.yml ====
package:
  name: ep_buffer_mem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ep_buf_mem_pkg.sv
      - rtl/ep_buf_arb_pkg.sv
      - rtl/ep_xbar_if.sv
      - rtl/ep_client_port.sv
      - rtl/ep_bank.sv
      - rtl/ep_buffer_mem.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/ep_buffer_mem_assert.sv
      - tb/tb_ep_buffer_mem.sv

// ==== rtl/ep_bank.sv ====
`timescale 1ns/100ps
`include "ep_buf_consts.svh"

module ep_bank
   import ep_buf_mem_pkg::*, ep_buf_arb_pkg::*;
#(
   parameter int unsigned BANK_ID = 0
) (
   input  logic    clk,
   input  logic    rst_n,
   ep_xbar_if.bank xbar
);

   localparam int unsigned DEPTH = 1 << (`EP_ADDR_W - `EP_WORD_LSB);

   ep_client_vec_t col_req;
   ep_client_vec_t grant;
   ep_client_vec_t rd_vld_q;
   ep_word_addr_t  mem_addr;
   ep_data_t       mem_wdata;
   ep_data_t       rd_data_q;
   logic           mem_ce;
   logic           mem_wr;

   ep_data_t       mem [DEPTH];

   // ************************************************************
   // Arbitration
   // ************************************************************

   // Pick out this bank's column of the request matrix
   always_comb begin
      col_req = '0;
      for (int c = 0; c < `EP_NUM_CLIENTS; c++) begin
         col_req[c] = xbar.req[c][BANK_ID];
      end
   end

   // Isolate the lowest set bit, which is the highest priority requester
   assign grant = col_req & (~col_req + ep_client_vec_t'(1));

   for (genvar c = 0; c < `EP_NUM_CLIENTS; c++) begin : g_resp
      assign xbar.ack[c][BANK_ID]  = grant[c];
      assign xbar.dvld[c][BANK_ID] = rd_vld_q[c];
   end

   // ************************************************************
   // Client multiplexer
   // ************************************************************

   // One-hot grant, so an AND-OR mux is enough
   always_comb begin
      mem_addr  = '0;
      mem_wdata = '0;
      for (int c = 0; c < `EP_NUM_CLIENTS; c++) begin
         if (grant[c]) begin
            mem_addr  |= xbar.word_addr[c];
            mem_wdata |= xbar.wdata[c];
         end
      end
   end

   assign mem_ce = |grant;
   assign mem_wr = |(grant & EP_CLIENT_IS_WRITE);

   // ************************************************************
   // Single-port array and read path
   // ************************************************************
   always_ff @(posedge clk) begin
      if (mem_ce) begin
         if (mem_wr) begin
            mem[mem_addr] <= mem_wdata;
         end else begin
            rd_data_q <= mem[mem_addr];
         end
      end
   end

   // Remember which reader was served so its valid follows one cycle later
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_vld_q <= '0;
      end else begin
         rd_vld_q <= grant & ~EP_CLIENT_IS_WRITE;
      end
   end

   // Data bus stays quiet between reads so ports can OR the banks
   assign xbar.rdata[BANK_ID] = (|rd_vld_q) ? rd_data_q : '0;

endmodule

// ==== rtl/ep_buf_arb_pkg.sv ====
`include "ep_buf_consts.svh"

package ep_buf_arb_pkg;

   // One bit per client, lower index wins arbitration
   typedef logic [`EP_NUM_CLIENTS-1:0] ep_client_vec_t;

   // One bit per bank
   typedef logic [`EP_NUM_BANKS-1:0] ep_bank_vec_t;

   // ************************************************************
   // Client numbering, highest priority first
   // ************************************************************
   localparam int unsigned EP_CLI_USB_RD = 0;
   localparam int unsigned EP_CLI_USB_WR = 1;
   localparam int unsigned EP_CLI_DMA_RD = 2;
   localparam int unsigned EP_CLI_DMA_WR = 3;

   // Set for clients that write the buffer, clear for readers
   localparam ep_client_vec_t EP_CLIENT_IS_WRITE =
      ep_client_vec_t'((1 << EP_CLI_USB_WR) | (1 << EP_CLI_DMA_WR));

endpackage

// ==== rtl/ep_buf_consts.svh ====
`ifndef EP_BUF_CONSTS_SVH
`define EP_BUF_CONSTS_SVH

// Client byte address and data word widths
`define EP_ADDR_W       10
`define EP_DATA_W       32

// Bank and client counts
`define EP_NUM_BANKS    4
`define EP_NUM_CLIENTS  4

// Address split: [3:2] bank, [9:4] word inside the bank
`define EP_BANK_LSB     2
`define EP_WORD_LSB     4

`endif

// ==== rtl/ep_buf_mem_pkg.sv ====
`include "ep_buf_consts.svh"

package ep_buf_mem_pkg;

   // Byte address as seen by a client
   typedef logic [`EP_ADDR_W-1:0] ep_addr_t;

   // One endpoint buffer word
   typedef logic [`EP_DATA_W-1:0] ep_data_t;

   // Word index inside a single bank
   typedef logic [`EP_ADDR_W-`EP_WORD_LSB-1:0] ep_word_addr_t;

   // Bank number taken from the low address bits
   typedef logic [`EP_WORD_LSB-`EP_BANK_LSB-1:0] ep_bank_sel_t;

endpackage

// ==== rtl/ep_buffer_mem.sv ====
`timescale 1ns/100ps
`include "ep_buf_consts.svh"

module ep_buffer_mem
   import ep_buf_mem_pkg::*, ep_buf_arb_pkg::*;
(
   input  logic     clk,
   input  logic     rst_n,

   // USB read port
   input  logic     usb_rd_cen,
   input  ep_addr_t usb_rd_addr,
   output logic     usb_rd_ack,
   output ep_data_t usb_rd_dout,
   output logic     usb_rd_dvld,

   // USB write port
   input  logic     usb_wr_cen,
   input  ep_addr_t usb_wr_addr,
   input  ep_data_t usb_wr_din,
   output logic     usb_wr_ack,

   // DMA read port
   input  logic     dma_rd_cen,
   input  ep_addr_t dma_rd_addr,
   output logic     dma_rd_ack,
   output ep_data_t dma_rd_dout,
   output logic     dma_rd_dvld,

   // DMA write port
   input  logic     dma_wr_cen,
   input  ep_addr_t dma_wr_addr,
   input  ep_data_t dma_wr_din,
   output logic     dma_wr_ack
);

   logic     cen_arr  [`EP_NUM_CLIENTS];
   ep_addr_t addr_arr [`EP_NUM_CLIENTS];
   ep_data_t din_arr  [`EP_NUM_CLIENTS];
   logic     ack_arr  [`EP_NUM_CLIENTS];
   ep_data_t dout_arr [`EP_NUM_CLIENTS];
   logic     dvld_arr [`EP_NUM_CLIENTS];

   ep_xbar_if xbar ();

   // ************************************************************
   // Port to client index mapping
   // ************************************************************
   assign cen_arr[EP_CLI_USB_RD]  = usb_rd_cen;
   assign cen_arr[EP_CLI_USB_WR]  = usb_wr_cen;
   assign cen_arr[EP_CLI_DMA_RD]  = dma_rd_cen;
   assign cen_arr[EP_CLI_DMA_WR]  = dma_wr_cen;

   assign addr_arr[EP_CLI_USB_RD] = usb_rd_addr;
   assign addr_arr[EP_CLI_USB_WR] = usb_wr_addr;
   assign addr_arr[EP_CLI_DMA_RD] = dma_rd_addr;
   assign addr_arr[EP_CLI_DMA_WR] = dma_wr_addr;

   // Read clients have no write data
   assign din_arr[EP_CLI_USB_RD]  = '0;
   assign din_arr[EP_CLI_USB_WR]  = usb_wr_din;
   assign din_arr[EP_CLI_DMA_RD]  = '0;
   assign din_arr[EP_CLI_DMA_WR]  = dma_wr_din;

   assign usb_rd_ack  = ack_arr[EP_CLI_USB_RD];
   assign usb_wr_ack  = ack_arr[EP_CLI_USB_WR];
   assign dma_rd_ack  = ack_arr[EP_CLI_DMA_RD];
   assign dma_wr_ack  = ack_arr[EP_CLI_DMA_WR];

   assign usb_rd_dout = dout_arr[EP_CLI_USB_RD];
   assign usb_rd_dvld = dvld_arr[EP_CLI_USB_RD];
   assign dma_rd_dout = dout_arr[EP_CLI_DMA_RD];
   assign dma_rd_dvld = dvld_arr[EP_CLI_DMA_RD];

   // ************************************************************
   // Client ports and banks
   // ************************************************************
   for (genvar i = 0; i < `EP_NUM_CLIENTS; i++) begin : g_client
      if (EP_CLIENT_IS_WRITE[i]) begin : g_wr
         ep_client_port #(.CLIENT_ID(i)) u_port (
            .cen  (cen_arr[i]),
            .addr (addr_arr[i]),
            .din  (din_arr[i]),
            .ack  (ack_arr[i]),
            .dout (),
            .dvld (),
            .xbar (xbar)
         );
      end else begin : g_rd
         ep_client_port #(.CLIENT_ID(i)) u_port (
            .cen  (cen_arr[i]),
            .addr (addr_arr[i]),
            .din  (din_arr[i]),
            .ack  (ack_arr[i]),
            .dout (dout_arr[i]),
            .dvld (dvld_arr[i]),
            .xbar (xbar)
         );
      end
   end

   for (genvar b = 0; b < `EP_NUM_BANKS; b++) begin : g_bank
      ep_bank #(.BANK_ID(b)) u_bank (
         .clk   (clk),
         .rst_n (rst_n),
         .xbar  (xbar)
      );
   end

endmodule

// ==== rtl/ep_client_port.sv ====
`timescale 1ns/100ps
`include "ep_buf_consts.svh"

module ep_client_port
   import ep_buf_mem_pkg::*, ep_buf_arb_pkg::*;
#(
   parameter int unsigned CLIENT_ID = 0
) (
   input  logic      cen,
   input  ep_addr_t  addr,
   input  ep_data_t  din,
   output logic      ack,
   output ep_data_t  dout,
   output logic      dvld,
   ep_xbar_if.client xbar
);

   localparam bit IS_WRITE = EP_CLIENT_IS_WRITE[CLIENT_ID];

   ep_bank_sel_t bank_sel;
   ep_bank_vec_t bank_dvld;

   // ************************************************************
   // Request side
   // ************************************************************

   // Bank field sits just above the byte lanes
   assign bank_sel = addr[`EP_WORD_LSB-1:`EP_BANK_LSB];

   // One-hot request toward the addressed bank only
   assign xbar.req[CLIENT_ID] = cen ? (ep_bank_vec_t'(1) << bank_sel) : '0;

   assign xbar.word_addr[CLIENT_ID] = addr[`EP_ADDR_W-1:`EP_WORD_LSB];

   // Readers never present write data to the banks
   assign xbar.wdata[CLIENT_ID] = IS_WRITE ? din : '0;

   // ************************************************************
   // Response side
   // ************************************************************

   // At most one bank grants this client in a cycle
   assign ack = |xbar.ack[CLIENT_ID];

   // Banks raise dvld for readers only
   assign bank_dvld = xbar.dvld[CLIENT_ID];
   assign dvld      = |bank_dvld;

   // Collect read data from the bank that returned it
   always_comb begin
      dout = '0;
      for (int b = 0; b < `EP_NUM_BANKS; b++) begin
         if (bank_dvld[b]) begin
            dout |= xbar.rdata[b];
         end
      end
   end

endmodule

// ==== rtl/ep_xbar_if.sv ====
`timescale 1ns/100ps
`include "ep_buf_consts.svh"

interface ep_xbar_if
   import ep_buf_mem_pkg::*, ep_buf_arb_pkg::*;
();

   // ************************************************************
   // Client side, one row per client
   // ************************************************************
   ep_bank_vec_t  req       [`EP_NUM_CLIENTS];
   ep_word_addr_t word_addr [`EP_NUM_CLIENTS];
   ep_data_t      wdata     [`EP_NUM_CLIENTS];

   // Each bank drives its own bit of every client row
   wire ep_bank_vec_t ack  [`EP_NUM_CLIENTS];
   wire ep_bank_vec_t dvld [`EP_NUM_CLIENTS];

   // ************************************************************
   // Bank side
   // ************************************************************
   // Zero unless the bank has a read valid this cycle
   ep_data_t      rdata     [`EP_NUM_BANKS];

   modport client (
      output req, word_addr, wdata,
      input  ack, dvld, rdata
   );

   modport bank (
      input  req, word_addr, wdata,
      output ack, dvld, rdata
   );

endinterface

// ==== src.f ====
+incdir+rtl
rtl/ep_buf_mem_pkg.sv
rtl/ep_buf_arb_pkg.sv
rtl/ep_xbar_if.sv
rtl/ep_client_port.sv
rtl/ep_bank.sv
rtl/ep_buffer_mem.sv
tb/ep_buffer_mem_assert.sv
tb/tb_ep_buffer_mem.sv

// ==== tb/ep_buffer_mem_assert.sv ====
`timescale 1ns/100ps

module ep_buffer_mem_assert (
   input logic clk,
   input logic rst_n,
   input logic usb_rd_cen,
   input logic usb_wr_cen,
   input logic dma_rd_cen,
   input logic dma_wr_cen,
   input logic usb_rd_ack,
   input logic usb_wr_ack,
   input logic dma_rd_ack,
   input logic dma_wr_ack,
   input logic usb_rd_dvld,
   input logic dma_rd_dvld
);

   int err_cnt = 0;

   logic [3:0] cen_v;
   logic [3:0] ack_v;

   assign cen_v = {dma_wr_cen, dma_rd_cen, usb_wr_cen, usb_rd_cen};
   assign ack_v = {dma_wr_ack, dma_rd_ack, usb_wr_ack, usb_rd_ack};

   // ************************************************************
   // Read valid follows an acknowledged read by one cycle
   // ************************************************************
   a_usb_rd_vld: assert property (@(posedge clk) disable iff (!rst_n)
      usb_rd_ack |=> usb_rd_dvld)
   else begin
      $error("usb read acknowledged but no valid one cycle later");
      err_cnt++;
   end

   a_dma_rd_vld: assert property (@(posedge clk) disable iff (!rst_n)
      dma_rd_ack |=> dma_rd_dvld)
   else begin
      $error("dma read acknowledged but no valid one cycle later");
      err_cnt++;
   end

   // Valid never shows up on its own
   a_usb_vld_src: assert property (@(posedge clk) disable iff (!rst_n)
      usb_rd_dvld |-> $past(usb_rd_ack))
   else begin
      $error("usb read valid without an acknowledged read");
      err_cnt++;
   end

   a_dma_vld_src: assert property (@(posedge clk) disable iff (!rst_n)
      dma_rd_dvld |-> $past(dma_rd_ack))
   else begin
      $error("dma read valid without an acknowledged read");
      err_cnt++;
   end

   a_ack_cen: assert property (@(posedge clk) (ack_v & ~cen_v) == 4'b0000)
   else begin
      $error("acknowledge raised for a client without a request");
      err_cnt++;
   end

   // Valids are quiet when reset is released
   a_rst_vld: assert property (@(posedge clk) $rose(rst_n) |-> !usb_rd_dvld && !dma_rd_dvld)
   else begin
      $error("read valid high right after reset");
      err_cnt++;
   end

endmodule

// ==== tb/tb_ep_buffer_mem.sv ====
`timescale 1ns/100ps
`include "ep_buf_consts.svh"

module tb_ep_buffer_mem
   import ep_buf_mem_pkg::*, ep_buf_arb_pkg::*;
();

   localparam int MAX_CYCLES = 2000;
   localparam int MODEL_WORDS = 1 << (`EP_ADDR_W - `EP_BANK_LSB);

   logic clk, rst_n;
   logic usb_rd_cen, usb_wr_cen, dma_rd_cen, dma_wr_cen;
   ep_addr_t usb_rd_addr, usb_wr_addr, dma_rd_addr, dma_wr_addr;
   ep_data_t usb_wr_din, dma_wr_din;
   logic usb_rd_ack, usb_wr_ack, dma_rd_ack, dma_wr_ack;
   ep_data_t usb_rd_dout, dma_rd_dout;
   logic usb_rd_dvld, dma_rd_dvld;

   ep_client_vec_t ack_v;
   ep_addr_t addr_v [`EP_NUM_CLIENTS];
   ep_data_t din_v [`EP_NUM_CLIENTS];
   ep_data_t model [MODEL_WORDS];
   ep_data_t rd_exp [`EP_NUM_CLIENTS];
   ep_addr_t wr_addr [`EP_NUM_BANKS];
   logic [15:0] lfsr = 16'd87;
   string test_name = "reset";
   int err_cnt = 0;
   int test_cnt = 0;
   int test_err0 = 0;
   int cycles = 0;

   ep_buffer_mem dut (.*);

   bind ep_buffer_mem ep_buffer_mem_assert u_assert (
      .clk(clk), .rst_n(rst_n),
      .usb_rd_cen(usb_rd_cen), .usb_wr_cen(usb_wr_cen),
      .dma_rd_cen(dma_rd_cen), .dma_wr_cen(dma_wr_cen),
      .usb_rd_ack(usb_rd_ack), .usb_wr_ack(usb_wr_ack),
      .dma_rd_ack(dma_rd_ack), .dma_wr_ack(dma_wr_ack),
      .usb_rd_dvld(usb_rd_dvld), .dma_rd_dvld(dma_rd_dvld)
   );

   assign ack_v = {dma_wr_ack, dma_rd_ack, usb_wr_ack, usb_rd_ack};
   assign addr_v = '{usb_rd_addr, usb_wr_addr, dma_rd_addr, dma_wr_addr};
   assign din_v = '{32'h0, usb_wr_din, 32'h0, dma_wr_din};

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic ep_addr_t rand_addr(int bank);
      ep_word_addr_t w;
      w = ep_word_addr_t'(rand_bits(`EP_ADDR_W - `EP_WORD_LSB));
      return {w, ep_bank_sel_t'(bank), 2'b00};
   endfunction

   function automatic int error_total();
      return err_cnt + dut.u_assert.err_cnt;
   endfunction

   task automatic check_word(string what, ep_data_t exp, ep_data_t act);
      assert (act === exp)
      else begin
         $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_bit(string what, logic exp, logic act);
      assert (act === exp)
      else begin
         $display("[ERROR] %s %s: expected %b, actual %b", test_name, what, exp, act);
         err_cnt++;
      end
   endtask

   // ************************************************************
   // Reference model and read data checks, sampled mid-cycle
   // ************************************************************
   always @(negedge clk) begin
      if (rst_n) begin
         if (usb_rd_dvld) check_word("usb_rd_dout", rd_exp[EP_CLI_USB_RD], usb_rd_dout);
         if (dma_rd_dvld) check_word("dma_rd_dout", rd_exp[EP_CLI_DMA_RD], dma_rd_dout);
         // Reads see the array before this cycle's writes land
         for (int c = 0; c < `EP_NUM_CLIENTS; c++) begin
            if (ack_v[c] && !EP_CLIENT_IS_WRITE[c])
               rd_exp[c] = model[addr_v[c][`EP_ADDR_W-1:`EP_BANK_LSB]];
         end
         for (int c = 0; c < `EP_NUM_CLIENTS; c++) begin
            if (ack_v[c] && EP_CLIENT_IS_WRITE[c])
               model[addr_v[c][`EP_ADDR_W-1:`EP_BANK_LSB]] = din_v[c];
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("test failed");
         $finish;
      end
   end

   task automatic drive(int c, logic cen, ep_addr_t a, ep_data_t d);
      case (c)
         EP_CLI_USB_RD: begin
            usb_rd_cen  = cen;
            usb_rd_addr = a;
         end
         EP_CLI_USB_WR: begin
            usb_wr_cen  = cen;
            usb_wr_addr = a;
            usb_wr_din  = d;
         end
         EP_CLI_DMA_RD: begin
            dma_rd_cen  = cen;
            dma_rd_addr = a;
         end
         default: begin
            dma_wr_cen  = cen;
            dma_wr_addr = a;
            dma_wr_din  = d;
         end
      endcase
   endtask

   // Hold the request until the bank grants it
   task automatic access(int c, ep_addr_t a, ep_data_t d);
      @(posedge clk);
      #10;
      drive(c, 1'b1, a, d);
      do @(negedge clk); while (!ack_v[c]);
      @(posedge clk);
      #10;
      drive(c, 1'b0, '0, '0);
   endtask

   // Both clients hit one bank; the lower index goes first
   task automatic conflict(int hi, int lo, ep_addr_t a_hi, ep_addr_t a_lo);
      @(posedge clk);
      #10;
      drive(hi, 1'b1, a_hi, rand_bits(32));
      drive(lo, 1'b1, a_lo, rand_bits(32));
      @(negedge clk);
      check_bit($sformatf("client %0d ack", hi), 1'b1, ack_v[hi]);
      check_bit($sformatf("client %0d ack", lo), 1'b0, ack_v[lo]);
      @(posedge clk);
      #10;
      drive(hi, 1'b0, '0, '0);
      @(negedge clk);
      check_bit($sformatf("client %0d late ack", lo), 1'b1, ack_v[lo]);
      @(posedge clk);
      #10;
      drive(lo, 1'b0, '0, '0);
   endtask

   task automatic start_test(string name);
      test_name = name;
      test_err0 = error_total();
   endtask

   task automatic end_test();
      repeat (2) @(posedge clk);
      test_cnt++;
      $display("%s finished with %0d errors", test_name, error_total() - test_err0);
   endtask

   initial begin
      ep_addr_t a;
      for (int c = 0; c < `EP_NUM_CLIENTS; c++) drive(c, 1'b0, '0, '0);
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      #10;
      rst_n = 1'b1;

      start_test("idle_after_reset");
      repeat (4) begin
         @(negedge clk);
         check_bit("acks and valids", 1'b0, |{ack_v, usb_rd_dvld, dma_rd_dvld});
      end
      end_test();

      start_test("usb_write_read");
      for (int b = 0; b < `EP_NUM_BANKS; b++) begin
         wr_addr[b] = rand_addr(b);
         access(EP_CLI_USB_WR, wr_addr[b], rand_bits(32));
      end
      for (int b = 0; b < `EP_NUM_BANKS; b++) access(EP_CLI_USB_RD, wr_addr[b], '0);
      end_test();

      start_test("dma_shared_memory");
      for (int b = 0; b < `EP_NUM_BANKS; b++) begin
         a = rand_addr(b);
         access(EP_CLI_DMA_WR, a, rand_bits(32));
         access(EP_CLI_DMA_RD, a, '0);
         access(EP_CLI_USB_RD, a, '0);
      end
      end_test();

      start_test("bank_conflict");
      a = rand_addr(1);
      conflict(EP_CLI_USB_WR, EP_CLI_DMA_WR, a, a ^ 10'h010);
      conflict(EP_CLI_USB_RD, EP_CLI_DMA_RD, a ^ 10'h010, a);
      end_test();

      start_test("four_banks_parallel");
      @(posedge clk);
      #10;
      drive(EP_CLI_USB_RD, 1'b1, wr_addr[0], '0);
      drive(EP_CLI_USB_WR, 1'b1, rand_addr(1), rand_bits(32));
      drive(EP_CLI_DMA_RD, 1'b1, wr_addr[2], '0);
      drive(EP_CLI_DMA_WR, 1'b1, rand_addr(3), rand_bits(32));
      @(negedge clk);
      check_bit("all four acks", 1'b1, &ack_v);
      @(posedge clk);
      #10;
      for (int c = 0; c < `EP_NUM_CLIENTS; c++) drive(c, 1'b0, '0, '0);
      @(negedge clk);
      check_bit("usb_rd_dvld", 1'b1, usb_rd_dvld);
      check_bit("dma_rd_dvld", 1'b1, dma_rd_dvld);
      end_test();

      $display("%0d tests run, %0d errors", test_cnt, error_total());
      if (error_total() == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule
